/* tl_cfg.svh */
`ifndef TL_CFG_SVH
`define TL_CFG_SVH

// Address bus width in bits
`define TL_AW 32

// Data bus width in bits, always a whole number of bytes
`define TL_DW 32

// Source ID width
// Must cover at least twice the outstanding limit so IDs stay unique
`define TL_SW 2

// Outstanding requests per host port
`define TL_MAX_REQS 2

`endif

/* tl_pkg.sv */
`include "tl_cfg.svh"

package tl_pkg;

    typedef logic [`TL_AW-1:0]   tl_addr_t;
    typedef logic [`TL_DW-1:0]   tl_data_t;
    typedef logic [`TL_DW/8-1:0] tl_mask_t;
    typedef logic [`TL_SW-1:0]   tl_source_t;
    // One even parity bit per data byte
    typedef logic [`TL_DW/8-1:0] tl_intg_t;

    // TL-UL opcode encodings
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        AccessAck     = 3'h0,
        AccessAckData = 3'h1
    } tl_d_op_e;

    typedef struct packed {
        logic       a_valid;
        tl_a_op_e   a_opcode;
        tl_addr_t   a_address;
        tl_mask_t   a_mask;
        tl_source_t a_source;
        tl_data_t   a_data;
        tl_intg_t   a_user_intg;
        logic       a_user_instr;
        logic       d_ready;
    } tl_h2d_t;

    typedef struct packed {
        logic       d_valid;
        tl_d_op_e   d_opcode;
        tl_source_t d_source;
        tl_data_t   d_data;
        tl_intg_t   d_user_intg;
        logic       d_error;
        logic       a_ready;
    } tl_d2h_t;

    // Bytewise even parity, shared by request and response paths
    function automatic tl_intg_t byte_parity(tl_data_t data);
        tl_intg_t par;
        for (int i = 0; i < `TL_DW / 8; i++) begin
            par[i] = ^data[8*i +: 8];
        end
        return par;
    endfunction

endpackage

/* core_bus_pkg.sv */
package core_bus_pkg;

    // Request as presented by a core memory port
    typedef struct packed {
        tl_pkg::tl_addr_t addr;
        logic             we;
        tl_pkg::tl_mask_t be;
        tl_pkg::tl_data_t wdata;
    } core_req_t;

    // Response returned to the core with the rsp_valid strobe
    typedef struct packed {
        tl_pkg::tl_data_t rdata;
        logic             err;
        logic             intg_err;
    } core_rsp_t;

    // Occupancy of the outstanding request window
    typedef enum logic [1:0] {
        Idle,
        Busy,
        Full
    } adapter_state_e;

endpackage

/* tl_a_packer.sv */
`timescale 1ns/10ps

module tl_a_packer #(
    parameter bit IsInstr = 1'b0
) (
    input  core_bus_pkg::core_req_t req_i,
    input  tl_pkg::tl_source_t      source_i,
    output tl_pkg::tl_h2d_t         tl_a_o
);

    tl_pkg::tl_data_t a_data;

    // Reads carry no payload
    assign a_data = req_i.we ? req_i.wdata : '0;

    always_comb begin
        tl_a_o = '0;

        if (!req_i.we) begin
            tl_a_o.a_opcode = tl_pkg::Get;
        end else if (&req_i.be) begin
            tl_a_o.a_opcode = tl_pkg::PutFullData;
        end else begin
            tl_a_o.a_opcode = tl_pkg::PutPartialData;
        end

        tl_a_o.a_address    = req_i.addr;
        tl_a_o.a_mask       = req_i.be;
        tl_a_o.a_source     = source_i;
        tl_a_o.a_data       = a_data;
        // Parity covers every lane, masked or not
        tl_a_o.a_user_intg  = tl_pkg::byte_parity(a_data);
        tl_a_o.a_user_instr = IsInstr;
    end

endmodule

/* tl_d_checker.sv */
`timescale 1ns/10ps

module tl_d_checker (
    input  tl_pkg::tl_d2h_t         tl_d_i,
    input  tl_pkg::tl_source_t      exp_source_i,
    output logic                    rsp_valid_o,
    output core_bus_pkg::core_rsp_t rsp_o,
    output logic                    source_err_o
);

    tl_pkg::tl_intg_t calc_intg;
    logic             has_data;

    assign has_data  = tl_d_i.d_opcode == tl_pkg::AccessAckData;
    assign calc_intg = tl_pkg::byte_parity(tl_d_i.d_data);

    assign rsp_valid_o = tl_d_i.d_valid;

    always_comb begin
        rsp_o = '0;
        if (has_data) begin
            rsp_o.rdata = tl_d_i.d_data;
        end
        rsp_o.err = tl_d_i.d_valid & tl_d_i.d_error;
        // Write acks carry no data to check
        rsp_o.intg_err = tl_d_i.d_valid & has_data & (calc_intg != tl_d_i.d_user_intg);
    end

    // Responses must come back in issue order
    assign source_err_o = tl_d_i.d_valid & (tl_d_i.d_source != exp_source_i);

endmodule

/* tl_host_adapter.sv */
`timescale 1ns/10ps

`include "tl_cfg.svh"

module tl_host_adapter #(
    parameter bit IsInstr = 1'b0
) (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    req_i,
    input  core_bus_pkg::core_req_t core_req_i,
    output logic                    gnt_o,
    output logic                    rsp_valid_o,
    output core_bus_pkg::core_rsp_t rsp_o,

    output tl_pkg::tl_h2d_t         tl_o,
    input  tl_pkg::tl_d2h_t         tl_i
);

    localparam int unsigned CntW = $clog2(`TL_MAX_REQS + 1);
    localparam logic [CntW-1:0] MaxCnt = CntW'(`TL_MAX_REQS);

    logic [CntW-1:0]             out_cnt;
    core_bus_pkg::adapter_state_e state;
    tl_pkg::tl_source_t          issue_src;
    tl_pkg::tl_source_t          retire_src;

    tl_pkg::tl_h2d_t             a_fields;
    logic                        a_valid;
    logic                        accept;
    logic                        retire;

    logic                        chk_valid;
    core_bus_pkg::core_rsp_t     chk_rsp;
    logic                        src_err;

    always_comb begin
        if (out_cnt == '0) begin
            state = core_bus_pkg::Idle;
        end else if (out_cnt == MaxCnt) begin
            state = core_bus_pkg::Full;
        end else begin
            state = core_bus_pkg::Busy;
        end
    end

    assign a_valid = req_i & (state != core_bus_pkg::Full);
    assign accept  = a_valid & tl_i.a_ready;
    assign gnt_o   = accept;

    // Stray D beats with nothing outstanding are dropped
    assign retire      = chk_valid & (state != core_bus_pkg::Idle);
    assign rsp_valid_o = retire;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_cnt    <= '0;
            issue_src  <= '0;
            retire_src <= '0;
        end else begin
            if (accept) begin
                issue_src <= issue_src + 1'b1;
            end
            if (retire) begin
                retire_src <= retire_src + 1'b1;
            end
            case ({accept, retire})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    tl_a_packer #(
        .IsInstr (IsInstr)
    ) u_a_packer (
        .req_i    (core_req_i),
        .source_i (issue_src ),
        .tl_a_o   (a_fields  )
    );

    always_comb begin
        tl_o         = a_fields;
        tl_o.a_valid = a_valid;
        tl_o.d_ready = 1'b1;
    end

    tl_d_checker u_d_checker (
        .tl_d_i       (tl_i      ),
        .exp_source_i (retire_src),
        .rsp_valid_o  (chk_valid ),
        .rsp_o        (chk_rsp   ),
        .source_err_o (src_err   )
    );

    // Out-of-order source reported as a bus error
    always_comb begin
        rsp_o     = chk_rsp;
        rsp_o.err = chk_rsp.err | src_err;
    end

endmodule

/* core_tl_wrapper.sv */
`timescale 1ns/10ps

module core_tl_wrapper (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // Instruction port
    input  logic                    instr_req_i,
    input  tl_pkg::tl_addr_t        instr_addr_i,
    output logic                    instr_gnt_o,
    output logic                    instr_rsp_valid_o,
    output core_bus_pkg::core_rsp_t instr_rsp_o,

    // Data port
    input  logic                    data_req_i,
    input  core_bus_pkg::core_req_t data_req_i_fields,
    output logic                    data_gnt_o,
    output logic                    data_rsp_valid_o,
    output core_bus_pkg::core_rsp_t data_rsp_o,

    // TL-UL host ports
    output tl_pkg::tl_h2d_t         tl_i_o,
    input  tl_pkg::tl_d2h_t         tl_i_i,
    output tl_pkg::tl_h2d_t         tl_d_o,
    input  tl_pkg::tl_d2h_t         tl_d_i
);

    core_bus_pkg::core_req_t instr_core_req;

    // Fetches are always full-word reads
    assign instr_core_req = '{addr: instr_addr_i, we: 1'b0, be: '1, wdata: '0};

    tl_host_adapter #(
        .IsInstr (1'b1)
    ) u_adapter_instr (
        .clk_i       (clk_i            ),
        .reset_i     (reset_i          ),
        .req_i       (instr_req_i      ),
        .core_req_i  (instr_core_req   ),
        .gnt_o       (instr_gnt_o      ),
        .rsp_valid_o (instr_rsp_valid_o),
        .rsp_o       (instr_rsp_o      ),
        .tl_o        (tl_i_o           ),
        .tl_i        (tl_i_i           )
    );

    tl_host_adapter #(
        .IsInstr (1'b0)
    ) u_adapter_data (
        .clk_i       (clk_i            ),
        .reset_i     (reset_i          ),
        .req_i       (data_req_i       ),
        .core_req_i  (data_req_i_fields),
        .gnt_o       (data_gnt_o       ),
        .rsp_valid_o (data_rsp_valid_o ),
        .rsp_o       (data_rsp_o       ),
        .tl_o        (tl_d_o           ),
        .tl_i        (tl_d_i           )
    );

endmodule

/* core_tl_properties.sv */
`timescale 1ns/10ps

`include "tl_cfg.svh"

module core_tl_properties (
    input logic                                clk_i,
    input logic                                reset_i,
    input logic                                req_i,
    input logic                                gnt_o,
    input logic                                rsp_valid_o,
    input tl_pkg::tl_h2d_t                     tl_o,
    input tl_pkg::tl_d2h_t                     tl_i,
    input logic [$clog2(`TL_MAX_REQS+1)-1:0] out_cnt
);

    // Grants not yet answered, counted from the port pins
    int pending;
    int fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(gnt_o) - int'(rsp_valid_o);
        end
    end

    // Quiet bus and empty window right after reset
    idle_after_reset: assert property (@(posedge clk_i)
        $past(reset_i) && !req_i |->
            out_cnt == '0 && !gnt_o && !tl_o.a_valid && !rsp_valid_o)
        else begin
            fail_count++;
            $error("Host adapter active right after reset");
        end

    gnt_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        gnt_o |-> tl_i.a_ready)
        else begin
            fail_count++;
            $error("Grant while a_ready low");
        end

    gnt_below_limit: assert property (@(posedge clk_i) disable iff (reset_i)
        gnt_o |-> pending < `TL_MAX_REQS)
        else begin
            fail_count++;
            $error("Grant with outstanding window full");
        end

    // A response needs a granted request still in flight
    rsp_needs_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> pending > 0)
        else begin
            fail_count++;
            $error("Response without an outstanding grant");
        end

    a_held_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
        tl_o.a_valid && !tl_i.a_ready |=> tl_o.a_valid && $stable(tl_o.a_address))
        else begin
            fail_count++;
            $error("A beat dropped or changed under back-pressure");
        end

    d_ready_high: assert property (@(posedge clk_i) disable iff (reset_i)
        tl_o.d_ready)
        else begin
            fail_count++;
            $error("d_ready low");
        end

endmodule

bind tl_host_adapter core_tl_properties u_props (.*);

/* tb_core_tl_wrapper.sv */
`timescale 1ns/10ps

module tl_device_model (
    input  logic            clk_i,
    input  logic            reset_i,
    input  tl_pkg::tl_h2d_t tl_h2d_i,
    output tl_pkg::tl_d2h_t tl_d2h_o
);

    tl_pkg::tl_data_t mem [tl_pkg::tl_addr_t];
    tl_pkg::tl_d2h_t  rsp_q [$];
    int               gap;

    // Accept A beats and queue the matching D beat
    always @(posedge clk_i) begin
        tl_pkg::tl_d2h_t  rsp;
        tl_pkg::tl_data_t word;
        if (!reset_i && tl_h2d_i.a_valid && tl_d2h_o.a_ready) begin
            word = mem.exists(tl_h2d_i.a_address) ? mem[tl_h2d_i.a_address]
                                                  : tb_core_tl_wrapper.fill_word(tl_h2d_i.a_address);
            rsp = '0;
            rsp.d_valid  = 1'b1;
            rsp.d_source = tl_h2d_i.a_source;
            rsp.d_error  = tl_h2d_i.a_address[5:2] == 4'hE;
            if (tl_h2d_i.a_opcode == tl_pkg::Get) begin
                rsp.d_opcode    = tl_pkg::AccessAckData;
                rsp.d_data      = word;
                rsp.d_user_intg = tb_core_tl_wrapper.lane_parity(word);
                // Marked address gets a broken parity bit
                if (tl_h2d_i.a_address[5:2] == 4'hD) begin
                    rsp.d_user_intg[0] = ~rsp.d_user_intg[0];
                end
            end else begin
                rsp.d_opcode = tl_pkg::AccessAck;
                for (int b = 0; b < 4; b++) begin
                    if (tl_h2d_i.a_mask[b]) begin
                        word[8*b +: 8] = tl_h2d_i.a_data[8*b +: 8];
                    end
                end
                mem[tl_h2d_i.a_address] = word;
            end
            rsp_q.push_back(rsp);
        end
    end

    always @(negedge clk_i) begin
        tl_pkg::tl_d2h_t beat;
        beat = '0;
        if (reset_i) begin
            gap = 0;
        end else begin
            if (gap > 0) begin
                gap--;
            end else if (rsp_q.size() > 0) begin
                beat = rsp_q.pop_front();
                gap  = $urandom % 6;
            end
            beat.a_ready = ($urandom % 4) != 0;
        end
        tl_d2h_o = beat;
    end

endmodule

module tb_core_tl_wrapper;

    typedef struct packed {
        logic             chk_data;
        tl_pkg::tl_data_t rdata;
        logic             err;
        logic             intg_err;
    } exp_rsp_t;

    logic                    clk;
    logic                    reset_i;
    logic                    instr_req;
    tl_pkg::tl_addr_t        instr_addr;
    logic                    instr_gnt, instr_rsp_valid;
    core_bus_pkg::core_rsp_t instr_rsp;
    logic                    data_req;
    core_bus_pkg::core_req_t data_fields;
    logic                    data_gnt, data_rsp_valid;
    core_bus_pkg::core_rsp_t data_rsp;
    tl_pkg::tl_h2d_t         tl_i_h2d, tl_d_h2d;
    tl_pkg::tl_d2h_t         tl_i_d2h, tl_d_d2h;

    exp_rsp_t                exp_data_q [$];
    exp_rsp_t                exp_instr_q [$];
    tl_pkg::tl_data_t        exp_mem [tl_pkg::tl_addr_t];
    int                      errors, data_gnts, data_rsps, instr_gnts, instr_rsps;
    bit                      timed_out;

    core_tl_wrapper core_tl_wrapper_inst (
        .clk_i             (clk            ),
        .reset_i           (reset_i        ),
        .instr_req_i       (instr_req      ),
        .instr_addr_i      (instr_addr     ),
        .instr_gnt_o       (instr_gnt      ),
        .instr_rsp_valid_o (instr_rsp_valid),
        .instr_rsp_o       (instr_rsp      ),
        .data_req_i        (data_req       ),
        .data_req_i_fields (data_fields    ),
        .data_gnt_o        (data_gnt       ),
        .data_rsp_valid_o  (data_rsp_valid ),
        .data_rsp_o        (data_rsp       ),
        .tl_i_o            (tl_i_h2d       ),
        .tl_i_i            (tl_i_d2h       ),
        .tl_d_o            (tl_d_h2d       ),
        .tl_d_i            (tl_d_d2h       )
    );

    tl_device_model u_instr_dev (.clk_i(clk), .reset_i(reset_i), .tl_h2d_i(tl_i_h2d),
                                 .tl_d2h_o(tl_i_d2h));
    tl_device_model u_data_dev (.clk_i(clk), .reset_i(reset_i), .tl_h2d_i(tl_d_h2d),
                                .tl_d2h_o(tl_d_d2h));

    initial clk = 1'b1;
    always #50 clk = ~clk;

    function automatic tl_pkg::tl_data_t fill_word(tl_pkg::tl_addr_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic tl_pkg::tl_intg_t lane_parity(tl_pkg::tl_data_t data);
        tl_pkg::tl_intg_t par;
        for (int b = 0; b < 4; b++) begin
            par[b] = ^data[8*b +: 8];
        end
        return par;
    endfunction

    function automatic exp_rsp_t expect_rsp(tl_pkg::tl_addr_t addr, logic we,
                                            tl_pkg::tl_data_t word);
        exp_rsp_t e;
        e.chk_data = !we;
        e.rdata    = word;
        e.err      = addr[5:2] == 4'hE;
        e.intg_err = !we && addr[5:2] == 4'hD;
        return e;
    endfunction

    task automatic compare_rsp(input exp_rsp_t e, input core_bus_pkg::core_rsp_t got,
                               input string port);
        if (e.chk_data) begin
            assert (got.rdata == e.rdata) else begin
                errors++;
                $display("Mismatch at %0t: %s rdata got %h expected %h", $time, port,
                         got.rdata, e.rdata);
            end
        end
        assert (got.err == e.err) else begin
            errors++;
            $display("Mismatch at %0t: %s err got %b expected %b", $time, port, got.err, e.err);
        end
        assert (got.intg_err == e.intg_err) else begin
            errors++;
            $display("Mismatch at %0t: %s intg_err got %b expected %b", $time, port,
                     got.intg_err, e.intg_err);
        end
    endtask

    // Scoreboard and A-beat checks, sampled where every input is settled
    always @(posedge clk) begin
        tl_pkg::tl_data_t word;
        tl_pkg::tl_a_op_e exp_op;
        if (!reset_i) begin
            if (data_rsp_valid) begin
                data_rsps++;
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("Data port returned a response with nothing outstanding");
                end else begin
                    compare_rsp(exp_data_q.pop_front(), data_rsp, "data_rsp_o");
                end
            end
            if (instr_rsp_valid) begin
                instr_rsps++;
                if (exp_instr_q.size() == 0) begin
                    errors++;
                    $display("Instruction port returned a response with nothing outstanding");
                end else begin
                    compare_rsp(exp_instr_q.pop_front(), instr_rsp, "instr_rsp_o");
                end
            end
            if (data_gnt) begin
                data_gnts++;
                exp_op = !data_fields.we ? tl_pkg::Get :
                         (&data_fields.be ? tl_pkg::PutFullData : tl_pkg::PutPartialData);
                assert (tl_d_h2d.a_opcode == exp_op) else begin
                    errors++;
                    $display("Mismatch at %0t: tl_d_o.a_opcode got %h expected %h", $time,
                             tl_d_h2d.a_opcode, exp_op);
                end
                if (data_fields.we) begin
                    assert (tl_d_h2d.a_user_intg == lane_parity(data_fields.wdata)) else begin
                        errors++;
                        $display("Mismatch at %0t: tl_d_o.a_user_intg got %h expected %h",
                                 $time, tl_d_h2d.a_user_intg, lane_parity(data_fields.wdata));
                    end
                end
                word = exp_mem.exists(data_fields.addr) ? exp_mem[data_fields.addr]
                                                        : fill_word(data_fields.addr);
                exp_data_q.push_back(expect_rsp(data_fields.addr, data_fields.we, word));
                if (data_fields.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_fields.be[b]) word[8*b +: 8] = data_fields.wdata[8*b +: 8];
                    end
                    exp_mem[data_fields.addr] = word;
                end
            end
            if (instr_gnt) begin
                instr_gnts++;
                assert (tl_i_h2d.a_opcode == tl_pkg::Get && tl_i_h2d.a_mask == 4'hF &&
                        tl_i_h2d.a_user_instr) else begin
                    errors++;
                    $display("Mismatch at %0t: tl_i_o op/mask/instr got %h %h %b expected 4 f 1",
                             $time, tl_i_h2d.a_opcode, tl_i_h2d.a_mask, tl_i_h2d.a_user_instr);
                end
                exp_instr_q.push_back(expect_rsp(instr_addr, 1'b0, fill_word(instr_addr)));
            end
        end
    end

    task automatic data_access(input tl_pkg::tl_addr_t addr, input logic we,
                               input tl_pkg::tl_mask_t be, input tl_pkg::tl_data_t wdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        data_req    = 1'b1;
        data_fields = '{addr: addr, we: we, be: be, wdata: wdata};
        @(posedge clk);
        while (!data_gnt && !timed_out) begin
            cycles++;
            if (cycles > 200) begin
                $display("Timeout: data port request was never granted");
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic instr_fetch(input tl_pkg::tl_addr_t addr);
        int cycles;
        cycles = 0;
        @(negedge clk);
        instr_req  = 1'b1;
        instr_addr = addr;
        @(posedge clk);
        while (!instr_gnt && !timed_out) begin
            cycles++;
            if (cycles > 200) begin
                $display("Timeout: instruction port request was never granted");
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic end_run();
        int prop_fails;
        prop_fails = core_tl_wrapper_inst.u_adapter_instr.u_props.fail_count
                   + core_tl_wrapper_inst.u_adapter_data.u_props.fail_count;
        $display("Closing counts: %0d errors, %0d property failures, timeout %0b, data %0d/%0d, instr %0d/%0d",
                 errors, prop_fails, timed_out, data_gnts, data_rsps, instr_gnts, instr_rsps);
        if (errors == 0 && prop_fails == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        int cycles;
        tl_pkg::tl_mask_t be;
        void'($urandom(32'h97fee6c0));
        reset_i = 1'b1;
        instr_req = 1'b0;
        instr_addr = '0;
        data_req = 1'b0;
        data_fields = '0;
        repeat (4) @(posedge clk);
        @(negedge clk) reset_i = 1'b0;
        repeat (3) @(negedge clk);
        fork
            begin
                for (int n = 0; n < 80 && !timed_out; n++) begin
                    be = ($urandom % 2) ? 4'hF : 4'(($urandom % 15) + 1);
                    data_access({26'h0, 4'($urandom % 16), 2'b00}, 1'($urandom % 2), be, $urandom);
                end
                for (int a = 0; a < 16 && !timed_out; a++) begin
                    data_access({26'h0, 4'(a), 2'b00}, 1'b0, 4'hF, '0);
                end
                @(negedge clk) data_req = 1'b0;
            end
            begin
                for (int n = 0; n < 60 && !timed_out; n++) begin
                    instr_fetch({24'h1, 2'b00, 4'($urandom % 16), 2'b00});
                end
                @(negedge clk) instr_req = 1'b0;
            end
        join
        cycles = 0;
        while ((exp_data_q.size() != 0 || exp_instr_q.size() != 0) && !timed_out) begin
            cycles++;
            if (cycles > 300) begin
                $display("Timeout: responses still outstanding after traffic ended");
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        assert (data_gnts == data_rsps && instr_gnts == instr_rsps) else begin
            errors++;
            $display("Mismatch at %0t: responses per grant got %0d/%0d expected %0d/%0d",
                     $time, data_rsps, instr_rsps, data_gnts, instr_gnts);
        end
        end_run();
    end

endmodule

/* files.f */
+incdir+.
tl_pkg.sv
core_bus_pkg.sv
tl_a_packer.sv
tl_d_checker.sv
tl_host_adapter.sv
core_tl_wrapper.sv
core_tl_properties.sv
tb_core_tl_wrapper.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_core_tl_wrapper
FILELIST  ?= files.f
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
